//--- compile.f
+incdir+.
telem_pkg.sv
uart_pkg.sv
axis_logger.sv
hex_dump.sv
uart_tx.sv
uart_rx.sv
telemetry_core.sv
tb_telemetry_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_telemetry_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP) with Verilator, result decided from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "test target: pass message found in $(LOG)"; \
	else \
		echo "test target: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_telemetry_core.sv
`include "telem_cfg.svh"

module tb_telemetry_core;

  timeunit 1ns;
  timeprecision 100ps;

  import telem_pkg::*;
  import uart_pkg::*;

  // Dumps before the overfill plus a full drain and one more after the refill
  localparam int NUM_DUMPS   = 4 + `FIFO_DEPTH / `PACKET_SIZE;
  localparam int DUMP_CYCLES = 72 * 10 * `UART_BIT_CYCLES;
  localparam int STIM_MARGIN = 20000;
  localparam int CYCLE_LIMIT = NUM_DUMPS * (DUMP_CYCLES + DUMP_CYCLES / 8) + STIM_MARGIN;

  logic      clock;
  logic      rst_i;
  logic      enable_i;
  sig_t      change_i;
  ign_t      ignore_i;
  logic      send_n_i;
  logic      uart_rx_i;
  logic      uart_tx_o;
  level_t    level_o;
  logic      dumping_o;

  integer    seed = 32'h0b96a022;
  int        mismatch_count;
  int        fail_count;
  int        cycles;
  log_word_t model_q[$];    // Expected FIFO contents in read order
  sig_t      model_last;    // Last change_i the logger registered
  int        reads_done;    // Words read since reset for the tlast position
  byte_t     rx_bytes[$];   // Bytes decoded from uart_tx_o

  telemetry_core i_telemetry_core (
    .clock     (clock),
    .rst_i     (rst_i),
    .enable_i  (enable_i),
    .change_i  (change_i),
    .ignore_i  (ignore_i),
    .send_n_i  (send_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .level_o   (level_o),
    .dumping_o (dumping_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Serial decoder sampling uart_tx_o near the middle of each bit
  initial begin : tx_decoder
    byte_t data;
    forever begin
      @(negedge clock);
      if (uart_tx_o === 1'b0) begin
        repeat (`UART_BIT_CYCLES / 2) @(negedge clock);
        if (uart_tx_o !== 1'b0) begin
          fail_count++;
          $display("start bit on uart_tx_o did not stay low");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (`UART_BIT_CYCLES) @(negedge clock);
          data[i] = uart_tx_o;  // LSB first
        end
        repeat (`UART_BIT_CYCLES) @(negedge clock);
        if (uart_tx_o !== 1'b1) begin
          fail_count++;
          $display("stop bit on uart_tx_o was low");
        end
        rx_bytes.push_back(data);
      end
    end
  end

  // One clock of capture stimulus with change detect and full drop in the model
  task automatic drive_capture(input logic en, input sig_t chg, input ign_t ign);
    @(negedge clock);
    enable_i = en;
    change_i = chg;
    ignore_i = ign;
    if (en && chg != model_last && model_q.size() < `FIFO_DEPTH) begin
      model_q.push_back({chg, ign});
    end
    model_last = chg;
  endtask

  task automatic random_burst(input int n_cycles, input int enable_pct);
    logic en;
    for (int i = 0; i < n_cycles; i++) begin
      en = ($unsigned($random(seed)) % 100) < enable_pct;
      drive_capture(en, sig_t'($random(seed)), ign_t'($random(seed)));
    end
  endtask

  // Inputs are held so the last capture lands before the compare
  task automatic check_level();
    repeat (3) @(negedge clock);
    if (level_o !== level_t'(model_q.size())) begin
      mismatch_count++;
      $display("mismatch level_o: got %h expected %h", level_o, level_t'(model_q.size()));
    end
  endtask

  task automatic top_up(input int min_words);
    while (model_q.size() < min_words) begin
      random_burst(16, 70);
    end
    check_level();
  endtask

  task automatic press_send();
    @(negedge clock);
    send_n_i = 1'b0;
    @(negedge clock);
    send_n_i = 1'b1;
  endtask

  // One 8N1 frame into uart_rx_i followed by one idle bit time
  task automatic send_serial(input byte_t data, input logic stop_bit);
    @(negedge clock);
    uart_rx_i = 1'b0;
    repeat (`UART_BIT_CYCLES) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = data[i];
      repeat (`UART_BIT_CYCLES) @(negedge clock);
    end
    uart_rx_i = stop_bit;
    repeat (`UART_BIT_CYCLES) @(negedge clock);
    uart_rx_i = 1'b1;
    repeat (`UART_BIT_CYCLES) @(negedge clock);
  endtask

  task automatic wait_dump_start(input int max_cycles);
    int waited;
    waited = 0;
    while (dumping_o !== 1'b1 && waited < max_cycles) begin
      @(negedge clock);
      waited++;
    end
    if (dumping_o !== 1'b1) begin
      fail_count++;
      $display("dump did not start within %0d cycles of the request", max_cycles);
    end
  endtask

  task automatic expect_no_dump(input int n_cycles);
    for (int i = 0; i < n_cycles; i++) begin
      @(negedge clock);
      if (dumping_o !== 1'b0) begin
        fail_count++;
        $display("dumping_o rose without a valid dump request");
        return;
      end
    end
  endtask

  // Expected text is 8 digits and LF for each model word up to the packet end
  task automatic check_dump_output();
    byte_t     expected[$];
    log_word_t word;
    string     digits;
    digits = "0123456789ABCDEF";
    do begin
      word = model_q.pop_front();
      reads_done++;
      for (int n = 7; n >= 0; n--) begin
        expected.push_back(digits.getc(word[n*4 +: 4]));
      end
      expected.push_back(8'h0A);
    end while (reads_done % `PACKET_SIZE != 0 && model_q.size() != 0);
    while (dumping_o === 1'b1) begin
      @(negedge clock);
    end
    repeat (12 * `UART_BIT_CYCLES) @(negedge clock);  // Newline frame drains
    if (rx_bytes.size() != expected.size()) begin
      fail_count++;
      $display("dump sent %0d bytes on uart_tx_o instead of %0d",
               rx_bytes.size(), expected.size());
    end
    for (int i = 0; i < expected.size() && i < rx_bytes.size(); i++) begin
      if (rx_bytes[i] !== expected[i]) begin
        mismatch_count++;
        $display("mismatch uart_tx_o byte %0d: got %h expected %h",
                 i, rx_bytes[i], expected[i]);
      end
    end
    if (dumping_o !== 1'b0) begin
      mismatch_count++;
      $display("mismatch dumping_o: got %h expected %h", dumping_o, 1'b0);
    end
    rx_bytes.delete();
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    byte_t other;
    rst_i          = 1'b1;
    enable_i       = 1'b0;
    change_i       = '0;
    ignore_i       = '0;
    send_n_i       = 1'b1;
    uart_rx_i      = 1'b1;  // Serial line idles high
    mismatch_count = 0;
    fail_count     = 0;
    reads_done     = 0;
    model_last     = '0;
    repeat (4) @(negedge clock);
    rst_i = 1'b0;

    // Idle state straight after reset
    @(negedge clock);
    if (uart_tx_o !== 1'b1) begin
      mismatch_count++;
      $display("mismatch uart_tx_o: got %h expected %h", uart_tx_o, 1'b1);
    end
    if (dumping_o !== 1'b0) begin
      mismatch_count++;
      $display("mismatch dumping_o: got %h expected %h", dumping_o, 1'b0);
    end
    if (level_o !== '0) begin
      mismatch_count++;
      $display("mismatch level_o: got %h expected %h", level_o, level_t'(0));
    end

    // Random captures with enable toggling
    for (int b = 0; b < 4; b++) begin
      random_burst(24, 50);
      check_level();
    end
    random_burst(16, 0);  // Enable low throughout
    check_level();
    for (int i = 0; i < 8; i++) begin
      drive_capture(1'b1, model_last, ign_t'($random(seed)));  // No change
    end
    check_level();

    // Dump started by the button
    top_up(8);
    press_send();
    wait_dump_start(4);
    check_dump_output();
    check_level();

    // Dump started by the serial command
    top_up(8);
    send_serial(`DUMP_CMD, 1'b1);
    wait_dump_start(4);
    check_dump_output();
    check_level();

    // Other byte and a bad stop bit start nothing
    top_up(8);
    do begin
      other = byte_t'($random(seed));
    end while (other == `DUMP_CMD);
    send_serial(other, 1'b1);
    expect_no_dump(32);
    send_serial(`DUMP_CMD, 1'b0);
    expect_no_dump(32);
    check_level();

    // Requests during a dump are ignored
    top_up(16);
    press_send();
    wait_dump_start(4);
    repeat (20) @(negedge clock);
    press_send();
    send_serial(`DUMP_CMD, 1'b1);
    check_dump_output();
    check_level();

    // Overfill then drain every stored word
    random_burst(200, 100);
    check_level();
    if (model_q.size() != `FIFO_DEPTH) begin
      fail_count++;
      $display("fill burst left the model with %0d words, not a full FIFO", model_q.size());
    end
    for (int d = 0; d < `FIFO_DEPTH / `PACKET_SIZE; d++) begin
      press_send();
      wait_dump_start(4);
      check_dump_output();
      check_level();
    end

    // Words captured after the drain follow the last word kept before the drop
    top_up(8);
    press_send();
    wait_dump_start(4);
    check_dump_output();
    check_level();

    repeat (10) @(negedge clock);
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- telemetry_core.sv
module telemetry_core (
  input  logic              clock,
  input  logic              rst_i,
  input  logic              enable_i,
  input  telem_pkg::sig_t   change_i,
  input  telem_pkg::ign_t   ignore_i,
  input  logic              send_n_i,
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  output telem_pkg::level_t level_o,
  output logic              dumping_o
);

  import telem_pkg::*;
  import uart_pkg::*;

  // Logger to dumper stream
  logic      log_tvalid;
  logic      log_tready;
  logic      log_tlast;
  log_word_t log_tdata;

  // Dumper to transmitter stream
  logic      tx_tvalid;
  logic      tx_tready;
  byte_t     tx_tdata;

  logic      rx_valid;  // Command byte strobe
  byte_t     rx_data;

  axis_logger i_axis_logger (
    .clock      (clock),
    .rst_i      (rst_i),
    .enable_i   (enable_i),
    .change_i   (change_i),
    .ignore_i   (ignore_i),
    .m_tready_i (log_tready),
    .m_tvalid_o (log_tvalid),
    .m_tlast_o  (log_tlast),
    .m_tdata_o  (log_tdata),
    .level_o    (level_o)
  );

  hex_dump i_hex_dump (
    .clock        (clock),
    .rst_i        (rst_i),
    .send_n_i     (send_n_i),
    .cmd_valid_i  (rx_valid),
    .cmd_data_i   (rx_data),
    .s_tvalid_i   (log_tvalid),
    .s_tlast_i    (log_tlast),
    .s_tdata_i    (log_tdata),
    .m_tready_i   (tx_tready),
    .s_tready_o   (log_tready),
    .m_tvalid_o   (tx_tvalid),
    .m_tdata_o    (tx_tdata),
    .is_dumping_o (dumping_o)
  );

  uart_tx i_uart_tx (
    .clock      (clock),
    .rst_i      (rst_i),
    .s_tvalid_i (tx_tvalid),
    .s_tdata_i  (tx_tdata),
    .s_tready_o (tx_tready),
    .txd_o      (uart_tx_o)
  );

  uart_rx i_uart_rx (
    .clock     (clock),
    .rst_i     (rst_i),
    .rxd_i     (uart_rx_i),
    .m_valid_o (rx_valid),
    .m_data_o  (rx_data)
  );

endmodule

//--- uart_rx.sv
`include "telem_cfg.svh"

module uart_rx (
  input  logic            clock,
  input  logic            rst_i,
  input  logic            rxd_i,
  output logic            m_valid_o,
  output uart_pkg::byte_t m_data_o
);

  import uart_pkg::*;

  localparam bit_cnt_t BIT_LAST  = bit_cnt_t'(`UART_BIT_CYCLES - 1);
  localparam bit_cnt_t HALF_LAST = bit_cnt_t'(`UART_BIT_CYCLES / 2 - 1);

  rx_state_t  state;
  logic [1:0] rxd_sync;  // Two-flop synchronizer
  logic       rxd_prev;  // For the falling edge
  logic       rxd;
  bit_cnt_t   cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;
  logic       valid_q;

  assign rxd = rxd_sync[1];

  always_ff @(posedge clock) begin
    if (rst_i) begin
      rxd_sync <= 2'b11;
      rxd_prev <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd_i};
      rxd_prev <= rxd;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (rxd_prev && !rxd) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Mid-start check filters glitches
          if (cnt == HALF_LAST) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == BIT_LAST) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == BIT_LAST) begin
            cnt     <= '0;
            valid_q <= rxd;  // Bad stop bit drops the byte
            state   <= RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, shift in from the top
  always_ff @(posedge clock) begin
    if (state == RX_DATA && cnt == BIT_LAST) begin
      shreg <= {rxd, shreg[7:1]};
    end
  end

  assign m_valid_o = valid_q;
  assign m_data_o  = shreg;  // Stable until the next frame's data bits

endmodule

//--- uart_tx.sv
`include "telem_cfg.svh"

module uart_tx (
  input  logic            clock,
  input  logic            rst_i,
  input  logic            s_tvalid_i,
  input  uart_pkg::byte_t s_tdata_i,
  output logic            s_tready_o,
  output logic            txd_o
);

  import uart_pkg::*;

  localparam bit_cnt_t BIT_LAST = bit_cnt_t'(`UART_BIT_CYCLES - 1);

  tx_state_t  state;
  bit_cnt_t   cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;    // Remaining data bits, LSB goes next
  logic       txd_q;
  logic       bit_end;

  assign bit_end = (cnt == BIT_LAST);

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd_q   <= 1'b1;  // Line idles high
    end else begin
      cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          if (s_tvalid_i) begin
            txd_q <= 1'b0;  // Start bit
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            txd_q   <= shreg[0];
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              txd_q <= 1'b1;  // Stop bit
              state <= TX_STOP;
            end else begin
              txd_q <= shreg[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == TX_IDLE && s_tvalid_i) begin
      shreg <= s_tdata_i;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shreg <= shreg >> 1;
    end
  end

  assign s_tready_o = (state == TX_IDLE);
  assign txd_o      = txd_q;

endmodule

//--- hex_dump.sv
`include "telem_cfg.svh"

module hex_dump (
  input  logic                 clock,
  input  logic                 rst_i,
  input  logic                 send_n_i,
  input  logic                 cmd_valid_i,
  input  uart_pkg::byte_t      cmd_data_i,
  input  logic                 s_tvalid_i,
  input  logic                 s_tlast_i,
  input  telem_pkg::log_word_t s_tdata_i,
  input  logic                 m_tready_i,
  output logic                 s_tready_o,
  output logic                 m_tvalid_o,
  output uart_pkg::byte_t      m_tdata_o,
  output logic                 is_dumping_o
);

  import telem_pkg::*;
  import uart_pkg::*;

  localparam int DIGITS = `LOG_WIDTH / 4;
  localparam int IDX_W  = $clog2(DIGITS);

  dump_state_t      state;
  logic             send_q;    // Registered button, active high
  logic             request;
  log_word_t        word_q;    // Shifted left one nibble per digit
  logic             last_q;    // Held word closes the packet
  logic [IDX_W-1:0] nib_idx;
  logic [3:0]       nibble;
  byte_t            hex_char;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      send_q <= 1'b0;
    end else begin
      send_q <= ~send_n_i;
    end
  end

  // Either source starts a dump, only looked at while idle
  assign request = send_q || (cmd_valid_i && cmd_data_i == `DUMP_CMD);

  assign nibble = word_q[`LOG_WIDTH-1 -: 4];

  always_comb begin
    if (nibble < 4'd10) begin
      hex_char = 8'h30 + {4'h0, nibble};  // 0..9
    end else begin
      hex_char = 8'h37 + {4'h0, nibble};  // A..F, uppercase
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state   <= IDLE;
      last_q  <= 1'b0;
      nib_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (request) begin
            state <= READ;
          end
        end
        READ: begin
          if (s_tvalid_i) begin
            last_q  <= s_tlast_i;
            nib_idx <= '0;
            state   <= DIGIT;
          end
        end
        DIGIT: begin
          if (m_tready_i) begin
            nib_idx <= nib_idx + 1'b1;
            if (nib_idx == IDX_W'(DIGITS - 1)) begin
              state <= NEWLINE;
            end
          end
        end
        NEWLINE: begin
          if (m_tready_i) begin
            state <= last_q ? IDLE : READ;  // One packet per dump
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload word, loaded on read and shifted per digit sent
  always_ff @(posedge clock) begin
    if (state == READ && s_tvalid_i) begin
      word_q <= s_tdata_i;
    end else if (state == DIGIT && m_tready_i) begin
      word_q <= word_q << 4;
    end
  end

  assign s_tready_o   = (state == READ);
  assign m_tvalid_o   = (state == DIGIT) || (state == NEWLINE);
  assign m_tdata_o    = (state == NEWLINE) ? 8'h0A : hex_char;
  assign is_dumping_o = (state != IDLE);

endmodule

//--- axis_logger.sv
`include "telem_cfg.svh"

module axis_logger (
  input  logic                clock,
  input  logic                rst_i,
  input  logic                enable_i,
  input  telem_pkg::sig_t     change_i,
  input  telem_pkg::ign_t     ignore_i,
  input  logic                m_tready_i,
  output logic                m_tvalid_o,
  output logic                m_tlast_o,
  output telem_pkg::log_word_t m_tdata_o,
  output telem_pkg::level_t   level_o
);

  import telem_pkg::*;

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int PKT_W = $clog2(`PACKET_SIZE);

  sig_t             change_q;     // Last value of the watched field
  logic             cap_valid_q;  // Capture pending for the FIFO
  log_word_t        cap_word_q;
  log_word_t        mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  level_t           level;
  logic [PKT_W-1:0] pkt_cnt;      // Words read inside the current packet
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (level == level_t'(`FIFO_DEPTH));
  assign wr_en = cap_valid_q && !full;  // Dropped when full
  assign rd_en = m_tvalid_o && m_tready_i;

  // Change detect, the word lands in the FIFO one cycle later
  always_ff @(posedge clock) begin
    if (rst_i) begin
      change_q    <= '0;
      cap_valid_q <= 1'b0;
    end else begin
      change_q    <= change_i;
      cap_valid_q <= enable_i && (change_i != change_q);
    end
  end

  always_ff @(posedge clock) begin
    cap_word_q <= {change_i, ignore_i};
  end

  // Circular buffer storage
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= cap_word_q;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level   <= '0;
      pkt_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
        if (pkt_cnt == PKT_W'(`PACKET_SIZE - 1)) begin
          pkt_cnt <= '0;  // Packet boundary passed
        end else begin
          pkt_cnt <= pkt_cnt + 1'b1;
        end
      end
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // Head word is stable until it is taken
  assign m_tvalid_o = (level != '0);
  assign m_tdata_o  = mem[rd_ptr];
  assign m_tlast_o  = (pkt_cnt == PKT_W'(`PACKET_SIZE - 1));
  assign level_o    = level;

endmodule

//--- uart_pkg.sv
`include "telem_cfg.svh"

package uart_pkg;

  typedef logic [7:0] byte_t;

  // Counts clocks inside one serial bit
  typedef logic [$clog2(`UART_BIT_CYCLES)-1:0] bit_cnt_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

//--- telem_pkg.sv
`include "telem_cfg.svh"

package telem_pkg;

  // One capture word, watched field on top
  typedef logic [`LOG_WIDTH-1:0] log_word_t;

  typedef logic [`SIG_WIDTH-1:0] sig_t;  // Watched signals
  typedef logic [`IGN_WIDTH-1:0] ign_t;  // Side bits, never trigger a capture

  // Fill level has to reach FIFO_DEPTH itself
  typedef logic [$clog2(`FIFO_DEPTH):0] level_t;

  typedef enum logic [1:0] {
    IDLE,     // Waiting for a request
    READ,     // Pulling the next word from the logger
    DIGIT,    // Sending hex digits of the held word
    NEWLINE   // Line feed after the last digit
  } dump_state_t;

endpackage

//--- telem_cfg.svh
`ifndef TELEM_CFG_SVH
`define TELEM_CFG_SVH

// Capture word layout
`define LOG_WIDTH 32
`define SIG_WIDTH 3
`define IGN_WIDTH 29

// Logger FIFO and packet framing
`define FIFO_DEPTH 64
`define PACKET_SIZE 8   // Words per packet, tlast on the last one

// Serial link
`define UART_BIT_CYCLES 16  // Clocks per bit
`define DUMP_CMD 8'h61      // ASCII "a"

`endif
